/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_x11_regs
FILELIST = x11_regs.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = *** TEST PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: compile
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* tests/tb_x11_regs.sv */
`timescale 1ns/1ps

module tb_x11_regs
  import x11_regs_pkg::*;
();

  typedef enum logic [1:0] {OP_WR, OP_RD, OP_HASH, OP_IDLE} op_e;

  // hash entries use wdata bit 0 to run the engine model and bit 1 for hash valid
  typedef struct packed {
    op_e         op;
    logic [19:0] addr;
    logic [31:0] wdata;   // write data, idle cycles or engine mode
    logic [31:0] exp;     // expected read value
    logic [7:0]  test;
  } entry_t;

  logic              clk_125mhz = 1'b0;
  logic              rstn_125mhz;
  sys_req_t          sys_req;
  sys_rsp_t          sys_rsp;
  logic              x11_activated_o;
  logic              sha256_rstn_o;
  logic              sha256_start_o;
  logic              engine_ready_i;
  logic              fifo_rd_en_i;
  logic [DATA_W-1:0] fifo_rd_data_o;
  logic              fifo_rd_vld_o;
  logic              fifo_empty_o;
  logic              hash_valid_i;
  logic [HASH_W-1:0] hash_i;

  entry_t      table_q[$];
  logic [31:0] words_q[$];   // lfsr push words
  logic [31:0] rx_q[$];      // words seen by the engine model
  entry_t      ent;
  logic [31:0] lfsr_q;
  logic [31:0] word;
  logic [31:0] rdata;
  logic [HASH_W-1:0] hash_val;
  logic        got_ack;
  logic        engine_run = 1'b0;
  int          test_errs = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  int          cycle_cnt = 0;
  int          cycle_limit = 0;

  always #4 clk_125mhz = ~clk_125mhz;  // 125 MHz

  x11_regs x11_regs_inst (
    .clk_125mhz      (clk_125mhz),
    .rstn_125mhz     (rstn_125mhz),
    .sys_req_i       (sys_req),
    .sys_rsp_o       (sys_rsp),
    .x11_activated_o (x11_activated_o),
    .sha256_rstn_o   (sha256_rstn_o),
    .sha256_start_o  (sha256_start_o),
    .engine_ready_i  (engine_ready_i),
    .fifo_rd_en_i    (fifo_rd_en_i),
    .fifo_rd_data_o  (fifo_rd_data_o),
    .fifo_rd_vld_o   (fifo_rd_vld_o),
    .fifo_empty_o    (fifo_empty_o),
    .hash_valid_i    (hash_valid_i),
    .hash_i          (hash_i)
  );

  bind x11_regs x11_regs_sva x11_regs_sva_inst (
    .clk_125mhz      (clk_125mhz),
    .rstn_125mhz     (rstn_125mhz),
    .sys_req_i       (sys_req_i),
    .sys_rsp_o       (sys_rsp_o),
    .x11_activated_o (x11_activated_o),
    .sha256_rstn_o   (sha256_rstn_o),
    .sha256_start_o  (sha256_start_o),
    .fifo_rd_en_i    (fifo_rd_en_i),
    .fifo_rd_vld_o   (fifo_rd_vld_o),
    .fifo_empty_o    (fifo_empty_o)
  );

  // galois form with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic [31:0] nxt;
    nxt = state >> 1;
    if (state[0]) nxt = nxt ^ 32'h80200003;
    return nxt;
  endfunction

  task automatic add_entry(input op_e op, input logic [19:0] addr, input logic [31:0] wdata,
                           input logic [31:0] exp, input int test);
    table_q.push_back('{op: op, addr: addr, wdata: wdata, exp: exp, test: 8'(test)});
  endtask

  // one strobe cycle then look for the registered ack
  task automatic bus_access(input logic is_wr, input logic [19:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rd,
                            output logic acked);
    int n;
    acked = 1'b0;
    rd    = '0;
    n     = 0;
    @(posedge clk_125mhz);
    sys_req.addr  <= {12'h000, addr};
    sys_req.wdata <= wdata;
    sys_req.wen   <= is_wr;
    sys_req.ren   <= !is_wr;
    @(posedge clk_125mhz);
    sys_req.wen <= 1'b0;
    sys_req.ren <= 1'b0;
    while (!acked && n < 4) begin
      @(negedge clk_125mhz);  // mid cycle where outputs are settled
      if (sys_rsp.ack) begin
        acked = 1'b1;
        rd    = sys_rsp.rdata;
      end
      n++;
    end
  endtask

  task automatic report_test(input int test);
    if (test_errs == 0) begin
      $display("test %0d passed", test);
      tests_passed++;
    end else begin
      $display("test %0d failed with %0d errors", test, test_errs);
      tests_failed++;
    end
    test_errs = 0;
  endtask

  // --------------------
  // engine model
  // --------------------
  always @(posedge clk_125mhz) begin
    if (!rstn_125mhz) begin
      fifo_rd_en_i <= 1'b0;
    end else begin
      fifo_rd_en_i <= engine_run && sha256_start_o && !fifo_empty_o;  // one pop per cycle
    end
    if (fifo_rd_vld_o) begin
      if (rx_q.size() >= 8) begin
        $display("engine model got more words from the FIFO than were pushed");
        test_errs++;
      end else if (fifo_rd_data_o !== words_q[rx_q.size()]) begin
        $display("error at %0t ns: engine word %0d is 0x%08h, expected 0x%08h", $time,
                 rx_q.size(), fifo_rd_data_o, words_q[rx_q.size()]);
        test_errs++;
      end
      rx_q.push_back(fifo_rd_data_o);
    end
  end

  // run limit
  always @(posedge clk_125mhz) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  initial begin
    rstn_125mhz    = 1'b0;
    sys_req        = '0;
    engine_ready_i = 1'b1;   // engine always ready
    fifo_rd_en_i   = 1'b0;
    hash_valid_i   = 1'b0;
    hash_i         = '0;

    // push words take 32 lfsr steps each
    lfsr_q = 32'h489847e7;
    for (int w = 0; w < 11; w++) begin
      for (int b = 0; b < 32; b++) begin
        lfsr_q  = lfsr_next(lfsr_q);
        word[b] = lfsr_q[0];
      end
      words_q.push_back(word);
    end

    // --------------------
    // stimulus table
    // --------------------
    // test 1 reset values
    add_entry(OP_RD, ADDR_CTRL, 0, 0, 1);
    add_entry(OP_RD, ADDR_STATUS, 0, 0, 1);
    add_entry(OP_RD, ADDR_VERSION, 0, CURRENT_DATE, 1);
    add_entry(OP_RD, ADDR_SHA_CTRL, 0, 0, 1);
    add_entry(OP_RD, ADDR_SHA_STATUS, 0, 32'h11, 1);  // ready and empty
    add_entry(OP_RD, ADDR_SHA_PUSH, 0, 0, 1);
    add_entry(OP_RD, ADDR_SHA_H7, 0, 0, 1);
    add_entry(OP_RD, ADDR_SHA_H0, 0, 0, 1);
    add_entry(OP_RD, ADDR_SHA_WR_COUNT, 0, 0, 1);
    add_entry(OP_RD, ADDR_SHA_RD_COUNT, 0, 0, 1);
    add_entry(OP_RD, 20'h00008, 0, 0, 1);             // unmapped
    add_entry(OP_RD, 20'h00200, 0, 0, 1);
    // test 2 control registers and activation
    add_entry(OP_WR, ADDR_CTRL, 1, 0, 2);
    add_entry(OP_RD, ADDR_CTRL, 0, 1, 2);
    add_entry(OP_RD, ADDR_STATUS, 0, 32'h01, 2);
    add_entry(OP_WR, ADDR_SHA_CTRL, 1, 0, 2);
    add_entry(OP_RD, ADDR_SHA_CTRL, 0, 1, 2);
    add_entry(OP_RD, ADDR_STATUS, 0, 32'h11, 2);
    add_entry(OP_WR, ADDR_CTRL, 0, 0, 2);
    add_entry(OP_RD, ADDR_STATUS, 0, 0, 2);           // sha bit falls too
    add_entry(OP_RD, ADDR_SHA_CTRL, 0, 1, 2);
    add_entry(OP_RD, ADDR_CTRL, 0, 0, 2);
    // test 3 pushes before and after activation
    add_entry(OP_WR, ADDR_SHA_PUSH, 32'h0bad0bad, 0, 3);  // dropped
    add_entry(OP_RD, ADDR_SHA_WR_COUNT, 0, 0, 3);
    add_entry(OP_RD, ADDR_SHA_PUSH, 0, 0, 3);
    add_entry(OP_WR, ADDR_CTRL, 1, 0, 3);
    add_entry(OP_RD, ADDR_CTRL, 0, 1, 3);
    add_entry(OP_RD, ADDR_STATUS, 0, 32'h11, 3);
    for (int k = 0; k < 8; k++) add_entry(OP_WR, ADDR_SHA_PUSH, words_q[k], 0, 3);
    add_entry(OP_RD, ADDR_SHA_WR_COUNT, 0, 8, 3);
    add_entry(OP_RD, ADDR_SHA_RD_COUNT, 0, 8, 3);
    add_entry(OP_RD, ADDR_SHA_STATUS, 0, 32'h01, 3);  // not empty
    // test 4 engine drains the fifo
    add_entry(OP_HASH, 0, 1, 0, 4);
    add_entry(OP_IDLE, 0, 20, 0, 4);
    add_entry(OP_RD, ADDR_SHA_STATUS, 0, 32'h11, 4);
    add_entry(OP_RD, ADDR_SHA_WR_COUNT, 0, 0, 4);
    add_entry(OP_RD, ADDR_SHA_RD_COUNT, 0, 0, 4);
    // test 5 hash capture puts word k in H(7-k)
    add_entry(OP_HASH, 0, 3, 0, 5);
    for (int k = 0; k < 8; k++) add_entry(OP_RD, 20'(ADDR_SHA_H7 + 4*k), 0, words_q[k], 5);
    add_entry(OP_RD, ADDR_SHA_STATUS, 0, 32'h13, 5);
    // test 6 one-shot engine reset
    add_entry(OP_HASH, 0, 0, 0, 6);
    add_entry(OP_WR, ADDR_SHA_PUSH, words_q[8], 0, 6);
    add_entry(OP_WR, ADDR_SHA_PUSH, words_q[9], 0, 6);
    add_entry(OP_RD, ADDR_SHA_WR_COUNT, 0, 2, 6);
    add_entry(OP_WR, ADDR_SHA_CTRL, 3, 0, 6);
    add_entry(OP_RD, ADDR_SHA_CTRL, 0, 1, 6);         // reset bit gone
    for (int k = 0; k < 8; k++) add_entry(OP_RD, 20'(ADDR_SHA_H7 + 4*k), 0, 0, 6);
    add_entry(OP_RD, ADDR_SHA_WR_COUNT, 0, 0, 6);
    add_entry(OP_RD, ADDR_STATUS, 0, 32'h11, 6);
    add_entry(OP_WR, ADDR_SHA_PUSH, words_q[10], 0, 6);
    add_entry(OP_RD, ADDR_SHA_WR_COUNT, 0, 1, 6);
    add_entry(OP_RD, ADDR_SHA_STATUS, 0, 32'h01, 6);

    cycle_limit = table_q.size() * 20 + 200;

    repeat (10) @(posedge clk_125mhz);
    rstn_125mhz <= 1'b1;
    @(negedge clk_125mhz);
    // activation, engine reset, start, read valid and ack all start inactive
    if ({x11_activated_o, sha256_rstn_o, sha256_start_o, fifo_rd_vld_o, sys_rsp.ack} !== 5'b0)
    begin
      $display("error at %0t ns: outputs active after reset, act %b rstn %b start %b vld %b ack %b",
               $time, x11_activated_o, sha256_rstn_o, sha256_start_o, fifo_rd_vld_o,
               sys_rsp.ack);
      test_errs++;
    end

    for (int i = 0; i < table_q.size(); i++) begin
      ent = table_q[i];
      case (ent.op)
        OP_WR, OP_RD: begin
          bus_access(ent.op == OP_WR, ent.addr, ent.wdata, rdata, got_ack);
          if (!got_ack) begin
            $display("test %0d: the DUT gave no ack for the %s at address 0x%05h", ent.test,
                     (ent.op == OP_WR) ? "write" : "read", ent.addr);
            test_errs++;
          end else if (ent.op == OP_RD && rdata !== ent.exp) begin
            $display("error at %0t ns: address 0x%05h read 0x%08h, expected 0x%08h", $time,
                     ent.addr, rdata, ent.exp);
            test_errs++;
          end
          // engine reset pin agrees with the sha activated status bit
          if (ent.op == OP_RD && ent.addr == ADDR_STATUS && sha256_rstn_o !== ent.exp[4]) begin
            $display("error at %0t ns: sha256_rstn_o is %b, expected %b", $time,
                     sha256_rstn_o, ent.exp[4]);
            test_errs++;
          end
          // start only with data in the fifo and a ready engine
          if (ent.op == OP_RD && ent.addr == ADDR_SHA_STATUS &&
              sha256_start_o !== (ent.exp[0] && !ent.exp[4])) begin
            $display("error at %0t ns: sha256_start_o is %b, expected %b", $time,
                     sha256_start_o, ent.exp[0] && !ent.exp[4]);
            test_errs++;
          end
        end
        OP_HASH: begin
          hash_val = '0;
          if (ent.wdata[1] && rx_q.size() != 8) begin
            $display("test %0d: engine model holds %0d words, not the 8 pushed", ent.test,
                     rx_q.size());
            test_errs++;
          end
          for (int k = 0; k < 8; k++) begin
            if (k < rx_q.size()) hash_val[k*DATA_W +: DATA_W] = rx_q[k];
          end
          @(posedge clk_125mhz);
          engine_run   <= ent.wdata[0];
          hash_i       <= hash_val;
          hash_valid_i <= ent.wdata[1];
        end
        default: begin
          repeat (ent.wdata) @(posedge clk_125mhz);
        end
      endcase
      if (i == table_q.size() - 1 || table_q[i+1].test != ent.test) report_test(ent.test);
    end

    $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* tests/x11_regs_sva.sv */
`timescale 1ns/1ps

module x11_regs_sva
  import x11_regs_pkg::*;
(
  input logic     clk_125mhz,
  input logic     rstn_125mhz,
  input sys_req_t sys_req_i,
  input sys_rsp_t sys_rsp_o,
  input logic     x11_activated_o,
  input logic     sha256_rstn_o,
  input logic     sha256_start_o,
  input logic     fifo_rd_en_i,
  input logic     fifo_rd_vld_o,
  input logic     fifo_empty_o
);

  // --------------------
  // bus timing
  // --------------------
  ack_after_strobe: assert property (@(posedge clk_125mhz) disable iff (!rstn_125mhz)
    (sys_req_i.wen || sys_req_i.ren) |=> sys_rsp_o.ack)
    else $error("ack missing one cycle after a bus strobe");

  ack_needs_strobe: assert property (@(posedge clk_125mhz) disable iff (!rstn_125mhz)
    sys_rsp_o.ack |-> $past(sys_req_i.wen || sys_req_i.ren))
    else $error("ack without a strobe in the cycle before");

  // --------------------
  // engine side
  // --------------------
  no_start_in_reset: assert property (@(posedge clk_125mhz) disable iff (!rstn_125mhz)
    !sha256_rstn_o |=> !sha256_start_o)
    else $error("start driven while the engine is held in reset");

  vld_after_accepted_rd: assert property (@(posedge clk_125mhz) disable iff (!rstn_125mhz)
    fifo_rd_vld_o |-> $past(fifo_rd_en_i && !fifo_empty_o))
    else $error("fifo read data valid without an accepted read");

  engine_reset_when_idle: assert property (@(posedge clk_125mhz) disable iff (!rstn_125mhz)
    !x11_activated_o |-> !sha256_rstn_o)
    else $error("engine out of reset while the block is not activated");

endmodule

/* verilog/activation.sv */
`timescale 1ns/1ps

module activation
  import x11_regs_pkg::*;
(
  input  logic clk_125mhz,
  input  logic rstn_125mhz,
  input  logic x11_enable_i,
  input  logic sha_enable_i,
  input  logic sha_soft_reset_i,
  output logic x11_activated_o,
  output logic sha_rstn_o        // also flushes fifo and hash words
);

  logic x11_act_q;
  logic sha_rstn_q;

  // block activation trails the enable bit by one cycle
  always_ff @(posedge clk_125mhz) begin
    if (!rstn_125mhz) begin
      x11_act_q <= 1'b0;
    end else begin
      x11_act_q <= x11_enable_i;
    end
  end

  // engine reset, released only when everything agrees
  always_ff @(posedge clk_125mhz) begin
    if (!rstn_125mhz) begin
      sha_rstn_q <= 1'b0;
    end else if (!x11_act_q) begin
      sha_rstn_q <= 1'b0;          // block not active
    end else if (!sha_enable_i) begin
      sha_rstn_q <= 1'b0;
    end else if (sha_soft_reset_i) begin
      sha_rstn_q <= 1'b0;          // one cycle engine reset
    end else begin
      sha_rstn_q <= 1'b1;
    end
  end

  assign x11_activated_o = x11_act_q;
  assign sha_rstn_o      = sha_rstn_q;

endmodule

/* verilog/reg_ctrl.sv */
`timescale 1ns/1ps

module reg_ctrl
  import x11_regs_pkg::*;
(
  input  logic       clk_125mhz,
  input  logic       rstn_125mhz,

  input  sys_req_t   sys_req_i,
  output sys_rsp_t   sys_rsp_o,

  output logic       x11_enable_o,
  output logic       sha_enable_o,      // already gated by x11 enable
  output logic       sha_soft_reset_o,  // one cycle pulse
  output push_t      push_o,

  input  logic       x11_activated_i,
  input  logic       sha_activated_i,
  input  fifo_stat_t fifo_stat_i,
  input  logic       engine_ready_i,
  input  logic       hash_valid_i,
  input  logic [HASH_WORDS-1:0][DATA_W-1:0] hash_words_i
);

  reg_addr_e         addr_dec;
  logic [DATA_W-1:0] ctrl_q;       // global control
  logic [DATA_W-1:0] sha_ctrl_q;   // sha-256 control
  logic              push_en_q;
  logic [DATA_W-1:0] push_data_q;
  logic [DATA_W-1:0] status;
  logic [DATA_W-1:0] sha_status;
  logic [DATA_W-1:0] rd_mux;
  logic [DATA_W-1:0] rdata_q;
  logic              ack_q;

  // only the low address bits take part in decoding
  assign addr_dec = reg_addr_e'(sys_req_i.addr[ADDR_DEC_W-1:0]);

  // --------------------
  // control registers
  // --------------------
  always_ff @(posedge clk_125mhz) begin
    if (!rstn_125mhz) begin
      ctrl_q     <= '0;
      sha_ctrl_q <= '0;
      push_en_q  <= 1'b0;
    end else begin
      sha_ctrl_q[SHA_CTRL_RESET_BIT] <= 1'b0;  // one-shot clears itself
      push_en_q                      <= 1'b0;
      if (sys_req_i.wen) begin
        case (addr_dec)
          ADDR_CTRL:     ctrl_q     <= sys_req_i.wdata;
          ADDR_SHA_CTRL: sha_ctrl_q <= sys_req_i.wdata;  // may set the one-shot again
          ADDR_SHA_PUSH: push_en_q  <= 1'b1;
          default: begin
          end
        endcase
      end
    end
  end

  // push word, qualified by push_en_q
  always_ff @(posedge clk_125mhz) begin
    if (sys_req_i.wen && (addr_dec == ADDR_SHA_PUSH)) begin
      push_data_q <= sys_req_i.wdata;
    end
  end

  assign x11_enable_o     = ctrl_q[CTRL_ENABLE_BIT];
  assign sha_enable_o     = sha_ctrl_q[SHA_CTRL_ENABLE_BIT] & x11_enable_o;
  assign sha_soft_reset_o = sha_ctrl_q[SHA_CTRL_RESET_BIT];
  assign push_o           = '{en: push_en_q, data: push_data_q};

  // --------------------
  // status words
  // --------------------
  always_comb begin
    status    = '0;
    status[0] = x11_activated_i;
    status[4] = sha_activated_i;  // engine out of reset

    sha_status    = '0;
    sha_status[0] = engine_ready_i;
    sha_status[1] = hash_valid_i;
    sha_status[4] = fifo_stat_i.empty;
    sha_status[5] = fifo_stat_i.almost_full;
    sha_status[6] = fifo_stat_i.full;
  end

  // --------------------
  // read mux
  // --------------------
  always_comb begin
    case (addr_dec)
      ADDR_CTRL:         rd_mux = ctrl_q;
      ADDR_STATUS:       rd_mux = status;
      ADDR_VERSION:      rd_mux = CURRENT_DATE;
      ADDR_SHA_CTRL:     rd_mux = sha_ctrl_q;
      ADDR_SHA_STATUS:   rd_mux = sha_status;
      ADDR_SHA_PUSH:     rd_mux = {{(DATA_W-FIFO_CNT_W){1'b0}}, fifo_stat_i.wr_count};
      ADDR_SHA_H7:       rd_mux = hash_words_i[7];  // lsb word
      ADDR_SHA_H6:       rd_mux = hash_words_i[6];
      ADDR_SHA_H5:       rd_mux = hash_words_i[5];
      ADDR_SHA_H4:       rd_mux = hash_words_i[4];
      ADDR_SHA_H3:       rd_mux = hash_words_i[3];
      ADDR_SHA_H2:       rd_mux = hash_words_i[2];
      ADDR_SHA_H1:       rd_mux = hash_words_i[1];
      ADDR_SHA_H0:       rd_mux = hash_words_i[0];  // msb word
      ADDR_SHA_WR_COUNT: rd_mux = {{(DATA_W-FIFO_CNT_W){1'b0}}, fifo_stat_i.wr_count};
      ADDR_SHA_RD_COUNT: rd_mux = {{(DATA_W-FIFO_CNT_W){1'b0}}, fifo_stat_i.rd_count};
      default:           rd_mux = '0;               // unmapped reads as zero
    endcase
  end

  // ack one cycle after any strobe
  always_ff @(posedge clk_125mhz) begin
    if (!rstn_125mhz) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= sys_req_i.wen | sys_req_i.ren;
    end
  end

  // read data lines up with ack
  always_ff @(posedge clk_125mhz) begin
    if (sys_req_i.ren) begin
      rdata_q <= rd_mux;
    end
  end

  assign sys_rsp_o = '{rdata: rdata_q, ack: ack_q};

endmodule

/* verilog/sha256_engine_link.sv */
`timescale 1ns/1ps

module sha256_engine_link
  import x11_regs_pkg::*;
(
  input  logic              clk_125mhz,
  input  logic              sha_rstn_i,
  input  logic              fifo_empty_i,
  input  logic              engine_ready_i,
  input  logic              hash_valid_i,
  input  logic [HASH_W-1:0] hash_i,
  output logic              start_o,
  output logic [HASH_WORDS-1:0][DATA_W-1:0] hash_words_o  // index k holds Hk
);

  logic start_q;
  logic hash_valid_d;    // for edge detect
  logic [HASH_WORDS-1:0][DATA_W-1:0] words_q;

  // start while there is data and the engine can take it
  always_ff @(posedge clk_125mhz) begin
    if (!sha_rstn_i) begin
      start_q <= 1'b0;
    end else begin
      start_q <= ~fifo_empty_i & engine_ready_i;
    end
  end

  // capture once per rising edge of hash valid
  always_ff @(posedge clk_125mhz) begin
    if (!sha_rstn_i) begin
      hash_valid_d <= 1'b0;
      words_q      <= '0;
    end else begin
      hash_valid_d <= hash_valid_i;
      if (hash_valid_i && !hash_valid_d) begin
        for (int k = 0; k < HASH_WORDS; k++) begin
          words_q[k] <= hash_i[(HASH_WORDS-1-k)*DATA_W +: DATA_W];  // H0 is the top word
        end
      end
    end
  end

  assign start_o      = start_q;
  assign hash_words_o = words_q;

endmodule

/* verilog/sha256_fifo.sv */
`timescale 1ns/1ps

module sha256_fifo
  import x11_regs_pkg::*;
(
  input  logic              clk_125mhz,
  input  logic              sha_rstn_i,
  input  push_t             push_i,
  input  logic              rd_en_i,
  output logic [DATA_W-1:0] rd_data_o,
  output logic              rd_vld_o,
  output fifo_stat_t        stat_o
);

  logic [DATA_W-1:0]     mem [FIFO_DEPTH];
  logic [FIFO_CNT_W-2:0] wr_ptr_q;    // wraps at FIFO_DEPTH
  logic [FIFO_CNT_W-2:0] rd_ptr_q;
  fifo_stat_t            stat_q;
  logic                  wr_acc;
  logic                  rd_acc;
  logic [FIFO_CNT_W-1:0] occ_nxt;
  logic [FIFO_CNT_W-1:0] rd_cnt_nxt;
  logic [DATA_W-1:0]     rd_data_q;
  logic                  rd_vld_q;

  assign wr_acc = push_i.en & ~stat_q.full;   // drop when full
  assign rd_acc = rd_en_i & ~stat_q.empty;

  // wr_count doubles as the occupancy counter
  assign occ_nxt    = stat_q.wr_count + FIFO_CNT_W'(wr_acc) - FIFO_CNT_W'(rd_acc);
  assign rd_cnt_nxt = stat_q.wr_count - FIFO_CNT_W'(rd_acc);  // newest write not yet visible

  // --------------------
  // pointers and flags
  // --------------------
  always_ff @(posedge clk_125mhz) begin
    if (!sha_rstn_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      stat_q   <= '{empty: 1'b1, almost_full: 1'b0, full: 1'b0,
                    wr_count: '0, rd_count: '0};
      rd_vld_q <= 1'b0;
    end else begin
      if (wr_acc) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (rd_acc) rd_ptr_q <= rd_ptr_q + 1'b1;
      stat_q.wr_count    <= occ_nxt;
      stat_q.rd_count    <= rd_cnt_nxt;
      stat_q.empty       <= (rd_cnt_nxt == '0);
      stat_q.almost_full <= (occ_nxt >= FIFO_CNT_W'(FIFO_AFULL_LEVEL));
      stat_q.full        <= (occ_nxt == FIFO_CNT_W'(FIFO_DEPTH));
      rd_vld_q           <= rd_acc;   // data follows rd_en by one cycle
    end
  end

  // --------------------
  // storage
  // --------------------
  always_ff @(posedge clk_125mhz) begin
    if (wr_acc) begin
      mem[wr_ptr_q] <= push_i.data;
    end
  end

  always_ff @(posedge clk_125mhz) begin
    if (rd_acc) begin
      rd_data_q <= mem[rd_ptr_q];
    end
  end

  assign rd_data_o = rd_data_q;
  assign rd_vld_o  = rd_vld_q;
  assign stat_o    = stat_q;

endmodule

/* verilog/x11_regs.sv */
`timescale 1ns/1ps

module x11_regs
  import x11_regs_pkg::*;
(
  input  logic              clk_125mhz,
  input  logic              rstn_125mhz,

  // system bus
  input  sys_req_t          sys_req_i,
  output sys_rsp_t          sys_rsp_o,

  // activation
  output logic              x11_activated_o,
  output logic              sha256_rstn_o,    // engine reset, active low

  // external sha-256 engine
  output logic              sha256_start_o,
  input  logic              engine_ready_i,
  input  logic              fifo_rd_en_i,
  output logic [DATA_W-1:0] fifo_rd_data_o,
  output logic              fifo_rd_vld_o,
  output logic              fifo_empty_o,
  input  logic              hash_valid_i,
  input  logic [HASH_W-1:0] hash_i
);

  logic       x11_enable;
  logic       sha_enable;
  logic       sha_soft_reset;
  logic       sha_rstn;
  push_t      push;
  fifo_stat_t fifo_stat;
  logic [HASH_WORDS-1:0][DATA_W-1:0] hash_words;  // index k holds Hk

  assign sha256_rstn_o = sha_rstn;
  assign fifo_empty_o  = fifo_stat.empty;

  reg_ctrl reg_ctrl_inst (
    .clk_125mhz       (clk_125mhz),
    .rstn_125mhz      (rstn_125mhz),
    .sys_req_i        (sys_req_i),
    .sys_rsp_o        (sys_rsp_o),
    .x11_enable_o     (x11_enable),
    .sha_enable_o     (sha_enable),
    .sha_soft_reset_o (sha_soft_reset),
    .push_o           (push),
    .x11_activated_i  (x11_activated_o),
    .sha_activated_i  (sha_rstn),
    .fifo_stat_i      (fifo_stat),
    .engine_ready_i   (engine_ready_i),
    .hash_valid_i     (hash_valid_i),
    .hash_words_i     (hash_words)
  );

  activation activation_inst (
    .clk_125mhz       (clk_125mhz),
    .rstn_125mhz      (rstn_125mhz),
    .x11_enable_i     (x11_enable),
    .sha_enable_i     (sha_enable),
    .sha_soft_reset_i (sha_soft_reset),
    .x11_activated_o  (x11_activated_o),
    .sha_rstn_o       (sha_rstn)
  );

  sha256_fifo sha256_fifo_inst (
    .clk_125mhz (clk_125mhz),
    .sha_rstn_i (sha_rstn),       // fifo is flushed with the engine
    .push_i     (push),
    .rd_en_i    (fifo_rd_en_i),
    .rd_data_o  (fifo_rd_data_o),
    .rd_vld_o   (fifo_rd_vld_o),
    .stat_o     (fifo_stat)
  );

  sha256_engine_link sha256_engine_link_inst (
    .clk_125mhz     (clk_125mhz),
    .sha_rstn_i     (sha_rstn),
    .fifo_empty_i   (fifo_stat.empty),
    .engine_ready_i (engine_ready_i),
    .hash_valid_i   (hash_valid_i),
    .hash_i         (hash_i),
    .start_o        (sha256_start_o),
    .hash_words_o   (hash_words)
  );

endmodule

/* verilog/x11_regs_pkg.sv */
package x11_regs_pkg;

  // -------------------
  // widths and constants
  // -------------------
  localparam int DATA_W           = 32;              // bus and fifo word
  localparam int ADDR_DEC_W       = 20;              // low address bits decoded
  localparam logic [31:0] CURRENT_DATE = 32'h16081101; // 0xYYMMDDss build stamp

  localparam int FIFO_DEPTH       = 256;             // power of two
  localparam int FIFO_CNT_W       = 9;               // holds 0..FIFO_DEPTH
  localparam int FIFO_AFULL_LEVEL = FIFO_DEPTH - 1;  // one slot left

  localparam int HASH_WORDS       = 8;               // H0..H7
  localparam int HASH_W           = 256;

  // control bit positions
  localparam int CTRL_ENABLE_BIT     = 0;            // global enable
  localparam int SHA_CTRL_ENABLE_BIT = 0;
  localparam int SHA_CTRL_RESET_BIT  = 1;            // self clearing

  // -------------------
  // register address map
  // -------------------
  typedef enum logic [ADDR_DEC_W-1:0] {
    ADDR_CTRL         = 20'h00000,
    ADDR_STATUS       = 20'h00004,
    ADDR_VERSION      = 20'h0000C,
    ADDR_SHA_CTRL     = 20'h00100,
    ADDR_SHA_STATUS   = 20'h00104,
    ADDR_SHA_PUSH     = 20'h0010C,  // write pushes, read gives wr_count
    ADDR_SHA_H7       = 20'h00110,  // lsb word of the hash
    ADDR_SHA_H6       = 20'h00114,
    ADDR_SHA_H5       = 20'h00118,
    ADDR_SHA_H4       = 20'h0011C,
    ADDR_SHA_H3       = 20'h00120,
    ADDR_SHA_H2       = 20'h00124,
    ADDR_SHA_H1       = 20'h00128,
    ADDR_SHA_H0       = 20'h0012C,  // msb word of the hash
    ADDR_SHA_WR_COUNT = 20'h00130,
    ADDR_SHA_RD_COUNT = 20'h00134
  } reg_addr_e;

  // -------------------
  // bundles
  // -------------------
  typedef struct packed {
    logic [31:0]       addr;
    logic [DATA_W-1:0] wdata;
    logic              wen;
    logic              ren;
  } sys_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              ack;
  } sys_rsp_t;

  typedef struct packed {
    logic                  empty;
    logic                  almost_full;
    logic                  full;
    logic [FIFO_CNT_W-1:0] wr_count;  // occupancy incl. newest write
    logic [FIFO_CNT_W-1:0] rd_count;  // words visible to the reader
  } fifo_stat_t;

  typedef struct packed {
    logic              en;
    logic [DATA_W-1:0] data;
  } push_t;

endpackage

/* x11_regs.f */
verilog/x11_regs_pkg.sv
verilog/activation.sv
verilog/sha256_fifo.sv
verilog/sha256_engine_link.sv
verilog/reg_ctrl.sv
verilog/x11_regs.sv
tests/x11_regs_sva.sv
tests/tb_x11_regs.sv
